/* axi_refill/axi_refill.sv */
// ------------------------------------------------
// AXI read refill unit
// Issues the line address, packs beats into a line
// ------------------------------------------------

`default_nettype none

`include "icache_config.svh"

module axi_refill
   import icache_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  rst_n,
   refill_if.refill   refill,
   output addr_t      m_araddr_o,
   output logic       m_arvalid_o,
   input  wire logic  m_arready_i,
   input  wire beat_t m_rdata_i,
   input  wire logic  m_rvalid_i,
   input  wire logic  m_rlast_i,
   output logic       m_rready_o
);

   localparam int BEATS = `ICACHE_BEATS;
   localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

   logic             open_q;    // Burst in progress
   logic             done_q;
   logic [CNT_W-1:0] beat_q;
   line_t            line_q;
   logic             beat_fire;

   assign beat_fire   = m_rvalid_i && open_q;
   assign m_rready_o  = open_q;
   assign refill.done = done_q;
   assign refill.line = line_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         m_arvalid_o <= 1'b0;
         open_q      <= 1'b0;
         done_q      <= 1'b0;
         beat_q      <= '0;
      end
      else
      begin
         done_q <= beat_fire && m_rlast_i;
         if (refill.start)
         begin
            m_arvalid_o <= 1'b1;
            open_q      <= 1'b1;
            beat_q      <= '0;
         end
         else
         begin
            if (m_arvalid_o && m_arready_i)
               m_arvalid_o <= 1'b0;
            if (beat_fire)
            begin
               beat_q <= beat_q + 1'b1;
               if (m_rlast_i)
                  open_q <= 1'b0;
            end
         end
      end
   end

   // Line-aligned address, beats enter from the top
   always_ff @(posedge clk)
   begin
      if (refill.start)
         m_araddr_o <= {refill.line_addr[ADDR_W-1:LINE_OFF_W], LINE_OFF_W'(0)};
      if (beat_fire)
         line_q <= {m_rdata_i, line_q[LINE_W-1:BEAT_W]};
   end

   a_last_on_final_beat: assert property (@(posedge clk) disable iff (!rst_n)
      beat_fire |-> (m_rlast_i == (beat_q == CNT_W'(BEATS - 1))));

   a_ar_held: assert property (@(posedge clk) disable iff (!rst_n)
      (m_arvalid_o && !m_arready_i) |=> (m_arvalid_o && $stable(m_araddr_o)));

endmodule

`default_nettype wire

/* common/icache_config.svh */
// ------------------------------------------------
// Instruction cache configuration
// Sizes and widths shared by the RTL and testbench
// ------------------------------------------------

`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

`define ICACHE_ADDR_W      32   // Fetch and bus address
`define ICACHE_FETCH_W     64   // One fetch word
`define ICACHE_ID_W        4
`define ICACHE_AXI_DATA_W  32   // Read bus beat
`define ICACHE_LINE_WORDS  2    // Fetch words per line

// Beats per refill burst follow from the widths above
`define ICACHE_BEATS ((`ICACHE_FETCH_W * `ICACHE_LINE_WORDS) / `ICACHE_AXI_DATA_W)

`define ICACHE_WAYS        2
`define ICACHE_SETS        16
`define ICACHE_REQ_DEPTH   2
`define ICACHE_STAT_W      32

`endif

/* common/icache_if.sv */
// ------------------------------------------------
// Instruction cache internal interfaces
// Refill request path and way array access
// ------------------------------------------------

`default_nettype none

// Controller to refill unit
interface refill_if
   import icache_pkg::*;
   ();

   logic  start;       // One-cycle pulse
   addr_t line_addr;
   logic  done;        // One-cycle pulse with the line
   line_t line;

   modport ctrl (
      output start,
      output line_addr,
      input  done,
      input  line
   );

   modport refill (
      input  start,
      input  line_addr,
      output done,
      output line
   );

endinterface

// Controller to tag, valid and data arrays
interface way_array_if
   import icache_pkg::*;
   ();

   logic                  lookup;
   index_t                index;
   tag_t                  tag;
   logic [WORD_SEL_W-1:0] word_sel;
   logic                  fill;
   line_t                 fill_line;
   logic                  flush;
   logic                  hit;       // One cycle after lookup
   fetch_word_t           hit_word;

   modport ctrl (
      output lookup, index, tag, word_sel, fill, fill_line, flush,
      input  hit, hit_word
   );

   modport ways (
      input  lookup, index, tag, word_sel, fill, fill_line, flush,
      output hit, hit_word
   );

endinterface

`default_nettype wire

/* common/icache_pkg.sv */
// ------------------------------------------------
// Instruction cache package
// Address, data and request types, address split
// ------------------------------------------------

`default_nettype none

`include "icache_config.svh"

package icache_pkg;

   localparam int ADDR_W     = `ICACHE_ADDR_W;
   localparam int FETCH_W    = `ICACHE_FETCH_W;
   localparam int BEAT_W     = `ICACHE_AXI_DATA_W;
   localparam int LINE_W     = `ICACHE_FETCH_W * `ICACHE_LINE_WORDS;
   localparam int BYTE_OFF_W = $clog2(FETCH_W / 8);
   localparam int WORD_SEL_W = $clog2(`ICACHE_LINE_WORDS);
   localparam int LINE_OFF_W = BYTE_OFF_W + WORD_SEL_W;
   localparam int INDEX_W    = $clog2(`ICACHE_SETS);
   localparam int TAG_W      = ADDR_W - LINE_OFF_W - INDEX_W;
   localparam int WAY_SEL_W  = $clog2(`ICACHE_WAYS);

   typedef logic [ADDR_W-1:0]          addr_t;
   typedef logic [`ICACHE_ID_W-1:0]    id_t;
   typedef logic [FETCH_W-1:0]         fetch_word_t;
   typedef logic [LINE_W-1:0]          line_t;
   typedef logic [BEAT_W-1:0]          beat_t;
   typedef logic [INDEX_W-1:0]         index_t;
   typedef logic [TAG_W-1:0]           tag_t;
   typedef logic [WAY_SEL_W-1:0]       way_sel_t;
   typedef logic [`ICACHE_STAT_W-1:0]  stat_t;

   typedef struct packed {
      addr_t addr;
      id_t   id;
   } fetch_req_t;

   // ------------------------------------------------
   // Address split
   // ------------------------------------------------
   function automatic tag_t addr_tag(input addr_t addr);
      return addr[ADDR_W-1 -: TAG_W];
   endfunction

   function automatic index_t addr_index(input addr_t addr);
      return addr[LINE_OFF_W +: INDEX_W];
   endfunction

   function automatic logic [WORD_SEL_W-1:0] addr_word(input addr_t addr);
      return addr[BYTE_OFF_W +: WORD_SEL_W];
   endfunction

endpackage

`default_nettype wire

/* hdl/fetch_req_queue.sv */
// ------------------------------------------------
// Fetch request queue
// Small FIFO in front of the lookup, drives grant
// ------------------------------------------------

`default_nettype none

`include "icache_config.svh"

module fetch_req_queue
   import icache_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire logic       fetch_req_i,
   input  wire addr_t      fetch_addr_i,
   input  wire id_t        fetch_id_i,
   output logic            fetch_grant_o,
   output logic            req_valid_o,
   output fetch_req_t      req_data_o,
   input  wire logic       req_pop_i,
   output logic            empty_o
);

   localparam int DEPTH = `ICACHE_REQ_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   fetch_req_t             mem [DEPTH];
   logic [PTR_W-1:0]       wr_ptr_q;
   logic [PTR_W-1:0]       rd_ptr_q;
   logic [CNT_W-1:0]       count_q;
   logic                   full;
   logic                   push;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full          = (count_q == CNT_W'(DEPTH));
   assign empty_o       = (count_q == '0);
   assign fetch_grant_o = !full;
   assign push          = fetch_req_i && !full;
   assign req_valid_o   = !empty_o;
   assign req_data_o    = mem[rd_ptr_q];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= ptr_next(wr_ptr_q);
         if (req_pop_i)
            rd_ptr_q <= ptr_next(rd_ptr_q);
         count_q <= count_q + CNT_W'(push) - CNT_W'(req_pop_i);
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr_q] <= '{addr: fetch_addr_i, id: fetch_id_i};
   end

   // The controller pops only what the queue holds
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      req_pop_i |-> !empty_o);

   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      count_q <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

/* hdl/icache_top.sv */
// ------------------------------------------------
// Two-way instruction cache, top level
// Fetch port in, AXI read channel out
// ------------------------------------------------

`default_nettype none

module icache_top
   import icache_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   rst_n,
   // Fetch port
   input  wire logic   fetch_req_i,
   output logic        fetch_grant_o,
   input  wire addr_t  fetch_addr_i,
   input  wire id_t    fetch_id_i,
   output logic        fetch_r_valid_o,
   output fetch_word_t fetch_r_rdata_o,
   output id_t         fetch_r_id_o,
   // AXI read channel
   output addr_t       m_araddr_o,
   output logic        m_arvalid_o,
   input  wire logic   m_arready_i,
   input  wire beat_t  m_rdata_i,
   input  wire logic   m_rvalid_i,
   input  wire logic   m_rlast_i,
   output logic        m_rready_o,
   // Control and statistics
   input  wire logic   ctrl_flush_req_i,
   output logic        ctrl_flush_ack_o,
   output logic        ctrl_pending_o,
   input  wire logic   stat_enable_i,
   input  wire logic   stat_clear_i,
   output stat_t       hit_count_o,
   output stat_t       miss_count_o,
   output stat_t       trans_count_o
);

   logic       req_valid;
   logic       req_pop;
   logic       queue_empty;
   fetch_req_t req_data;

   refill_if    u_refill_if ();
   way_array_if u_way_if ();

   fetch_req_queue u_req_queue (
      .clk           (clk),
      .rst_n         (rst_n),
      .fetch_req_i   (fetch_req_i),
      .fetch_addr_i  (fetch_addr_i),
      .fetch_id_i    (fetch_id_i),
      .fetch_grant_o (fetch_grant_o),
      .req_valid_o   (req_valid),
      .req_data_o    (req_data),
      .req_pop_i     (req_pop),
      .empty_o       (queue_empty)
   );

   icache_ctrl u_ctrl (
      .clk              (clk),
      .rst_n            (rst_n),
      .req_valid_i      (req_valid),
      .req_data_i       (req_data),
      .req_pop_o        (req_pop),
      .queue_empty_i    (queue_empty),
      .way              (u_way_if.ctrl),
      .refill           (u_refill_if.ctrl),
      .fetch_r_valid_o  (fetch_r_valid_o),
      .fetch_r_rdata_o  (fetch_r_rdata_o),
      .fetch_r_id_o     (fetch_r_id_o),
      .ctrl_flush_req_i (ctrl_flush_req_i),
      .ctrl_flush_ack_o (ctrl_flush_ack_o),
      .ctrl_pending_o   (ctrl_pending_o),
      .stat_enable_i    (stat_enable_i),
      .stat_clear_i     (stat_clear_i),
      .hit_count_o      (hit_count_o),
      .miss_count_o     (miss_count_o),
      .trans_count_o    (trans_count_o)
   );

   icache_ways u_ways (
      .clk   (clk),
      .rst_n (rst_n),
      .way   (u_way_if.ways)
   );

   axi_refill u_refill (
      .clk         (clk),
      .rst_n       (rst_n),
      .refill      (u_refill_if.refill),
      .m_araddr_o  (m_araddr_o),
      .m_arvalid_o (m_arvalid_o),
      .m_arready_i (m_arready_i),
      .m_rdata_i   (m_rdata_i),
      .m_rvalid_i  (m_rvalid_i),
      .m_rlast_i   (m_rlast_i),
      .m_rready_o  (m_rready_o)
   );

endmodule

`default_nettype wire

/* icache_core/icache_ctrl.sv */
// ------------------------------------------------
// Instruction cache controller
// Lookup and miss FSM, flush handling, statistics
// ------------------------------------------------

`default_nettype none

module icache_ctrl
   import icache_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire logic        req_valid_i,
   input  wire fetch_req_t  req_data_i,
   output logic             req_pop_o,
   input  wire logic        queue_empty_i,
   way_array_if.ctrl        way,
   refill_if.ctrl           refill,
   output logic             fetch_r_valid_o,
   output fetch_word_t      fetch_r_rdata_o,
   output id_t              fetch_r_id_o,
   input  wire logic        ctrl_flush_req_i,
   output logic             ctrl_flush_ack_o,
   output logic             ctrl_pending_o,
   input  wire logic        stat_enable_i,
   input  wire logic        stat_clear_i,
   output stat_t            hit_count_o,
   output stat_t            miss_count_o,
   output stat_t            trans_count_o
);

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      REFILL,
      RELOOK,
      FLUSH
   } state_e;

   state_e     state_q;
   state_e     state_d;
   fetch_req_t req_q;       // Request under service
   addr_t      cur_addr;
   logic       pop;
   logic       respond;
   logic       first_hit;
   logic       first_miss;

   // Flush wins over a waiting request
   assign pop       = (state_q == IDLE) && req_valid_i && !ctrl_flush_req_i;
   assign req_pop_o = pop;

   // In IDLE the lookup runs straight off the queue head
   assign cur_addr = (state_q == IDLE) ? req_data_i.addr : req_q.addr;

   assign way.lookup    = pop || way.fill;
   assign way.index     = addr_index(cur_addr);
   assign way.tag       = addr_tag(cur_addr);
   assign way.word_sel  = addr_word(cur_addr);
   assign way.fill      = (state_q == REFILL) && refill.done;
   assign way.fill_line = refill.line;
   assign way.flush     = (state_q == IDLE) && ctrl_flush_req_i;

   assign first_hit  = (state_q == LOOKUP) && way.hit;
   assign first_miss = (state_q == LOOKUP) && !way.hit;

   assign refill.start     = first_miss;
   assign refill.line_addr = req_q.addr;

   assign respond          = first_hit || (state_q == RELOOK);
   assign ctrl_flush_ack_o = (state_q == FLUSH);   // Valid bits cleared last edge
   assign ctrl_pending_o   = !queue_empty_i || (state_q != IDLE) || fetch_r_valid_o;

   // ------------------------------------------------
   // State machine
   // ------------------------------------------------
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (ctrl_flush_req_i)
               state_d = FLUSH;
            else if (req_valid_i)
               state_d = LOOKUP;
         end
         LOOKUP:  state_d = way.hit ? IDLE : REFILL;
         REFILL:  state_d = refill.done ? RELOOK : REFILL;
         RELOOK:  state_d = IDLE;
         FLUSH:   state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q         <= IDLE;
         fetch_r_valid_o <= 1'b0;
      end
      else
      begin
         state_q         <= state_d;
         fetch_r_valid_o <= respond;
      end
   end

   always_ff @(posedge clk)
   begin
      if (pop)
         req_q <= req_data_i;
      if (respond)
      begin
         fetch_r_rdata_o <= way.hit_word;
         fetch_r_id_o    <= req_q.id;
      end
   end

   // ------------------------------------------------
   // Statistics
   // ------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         hit_count_o   <= '0;
         miss_count_o  <= '0;
         trans_count_o <= '0;
      end
      else if (stat_clear_i)
      begin
         hit_count_o   <= '0;
         miss_count_o  <= '0;
         trans_count_o <= '0;
      end
      else if (stat_enable_i)
      begin
         if (pop)
            trans_count_o <= trans_count_o + 1'b1;
         if (first_hit)
            hit_count_o <= hit_count_o + 1'b1;
         if (first_miss)
            miss_count_o <= miss_count_o + 1'b1;
      end
   end

   // The filled line must be found by the second lookup
   a_relook_hits: assert property (@(posedge clk) disable iff (!rst_n)
      (state_q == RELOOK) |-> way.hit);

endmodule

`default_nettype wire

/* icache_core/icache_ways.sv */
// ------------------------------------------------
// Instruction cache way arrays
// Tags, valid bits and lines per way, hit select,
// round-robin victim per set
// ------------------------------------------------

`default_nettype none

`include "icache_config.svh"

module icache_ways
   import icache_pkg::*;
(
   input  wire logic clk,
   input  wire logic rst_n,
   way_array_if.ways way
);

   localparam int WAYS = `ICACHE_WAYS;
   localparam int SETS = `ICACHE_SETS;

   tag_t                  tag_arr  [WAYS][SETS];
   line_t                 data_arr [WAYS][SETS];
   logic [WAYS-1:0][SETS-1:0] valid_q;
   way_sel_t [SETS-1:0]   rr_q;       // Next victim per set

   // Registered lookup address
   index_t                index_q;
   tag_t                  tag_q;
   logic [WORD_SEL_W-1:0] word_q;

   logic [WAYS-1:0]       hit_vec;
   way_sel_t              hit_way;
   way_sel_t              victim;
   line_t                 hit_line;

   assign victim = rr_q[way.index];

   always_ff @(posedge clk)
   begin
      if (way.lookup)
      begin
         index_q <= way.index;
         tag_q   <= way.tag;
         word_q  <= way.word_sel;
      end
      if (way.fill)
      begin
         tag_arr[victim][way.index]  <= way.tag;
         data_arr[victim][way.index] <= way.fill_line;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q <= '0;
         rr_q    <= '0;
      end
      else if (way.flush)
         valid_q <= '0;
      else if (way.fill)
      begin
         valid_q[victim][way.index] <= 1'b1;
         rr_q[way.index]            <= victim + 1'b1;
      end
   end

   // Parallel tag compare
   always_comb
   begin
      hit_way = '0;
      for (int w = 0; w < WAYS; w++)
      begin
         hit_vec[w] = valid_q[w][index_q] && (tag_arr[w][index_q] == tag_q);
         if (hit_vec[w])
            hit_way = way_sel_t'(w);
      end
   end

   assign hit_line     = data_arr[hit_way][index_q];
   assign way.hit      = |hit_vec;
   assign way.hit_word = hit_line[word_q*FETCH_W +: FETCH_W];

   // A line is never filled into a set that already holds it
   a_one_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(hit_vec));

endmodule

`default_nettype wire

/* sim/axi_mem_model.sv */
// ------------------------------------------------
// AXI read memory model for the testbench
// Answers line bursts from an address rule, with
// random ready and valid gaps
// ------------------------------------------------

`default_nettype none

`include "icache_config.svh"

module axi_mem_model
   import icache_pkg::*;
#(
   parameter beat_t DATA_KEY = '0
)
(
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wire addr_t araddr_i,
   input  wire logic  arvalid_i,
   output logic       arready_o,
   output beat_t      rdata_o,
   output logic       rvalid_o,
   output logic       rlast_o,
   input  wire logic  rready_i,
   output int         ar_count_o
);

   integer seed;
   logic   busy_q;    // Burst accepted, beats still to send
   addr_t  addr_q;    // Byte address of the next beat
   int     beat_q;

   initial
   begin
      seed      = 73;
      arready_o = 1'b0;
      rvalid_o  = 1'b0;
      rlast_o   = 1'b0;
      rdata_o   = '0;
   end

   // Transfers land on the rising edge
   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy_q     <= 1'b0;
         addr_q     <= '0;
         beat_q     <= 0;
         ar_count_o <= 0;
      end
      else if (arvalid_i && arready_o)
      begin
         busy_q     <= 1'b1;
         addr_q     <= araddr_i;
         beat_q     <= 0;
         ar_count_o <= ar_count_o + 1;
      end
      else if (rvalid_o && rready_i)
      begin
         addr_q <= addr_q + (`ICACHE_AXI_DATA_W / 8);
         beat_q <= beat_q + 1;
         if (rlast_o)
            busy_q <= 1'b0;
      end
   end

   // Outputs move on the falling edge
   always @(negedge clk)
   begin
      arready_o <= rst_n && !busy_q && ({$random(seed)} % 4 != 0);
      rvalid_o  <= rst_n && busy_q && ({$random(seed)} % 4 != 0);
      rdata_o   <= addr_q ^ DATA_KEY;    // Beat value follows its byte address
      rlast_o   <= (beat_q == `ICACHE_BEATS - 1);
   end

endmodule

`default_nettype wire

/* sim/icache_tb.sv */
// ------------------------------------------------
// Instruction cache testbench
// Table of fetch, flush and statistics operations
// checked against a response queue and counters
// ------------------------------------------------

`default_nettype none

module icache_tb
   import icache_pkg::*;
();

   localparam beat_t DATA_KEY = 32'h5A3C_96E1;

   typedef enum logic [2:0] {
      OP_FETCH, OP_SYNC, OP_FLUSH, OP_CLEAR, OP_STAT_OFF, OP_STAT_ON
   } op_e;

   typedef struct packed {
      op_e   op;
      addr_t addr;
      id_t   id;
      logic  hit;        // Expected first lookup result
      logic  rand_id;
   } row_t;

   logic        clk;
   logic        rst_n;
   logic        fetch_req_i;
   logic        fetch_grant_o;
   addr_t       fetch_addr_i;
   id_t         fetch_id_i;
   logic        fetch_r_valid_o;
   fetch_word_t fetch_r_rdata_o;
   id_t         fetch_r_id_o;
   addr_t       m_araddr;
   logic        m_arvalid;
   logic        m_arready;
   beat_t       m_rdata;
   logic        m_rvalid;
   logic        m_rlast;
   logic        m_rready;
   logic        ctrl_flush_req_i;
   logic        ctrl_flush_ack_o;
   logic        ctrl_pending_o;
   logic        stat_enable_i;
   logic        stat_clear_i;
   stat_t       hit_count_o;
   stat_t       miss_count_o;
   stat_t       trans_count_o;
   int          ar_count;

   row_t        rows [$];
   fetch_req_t  exp_q [$];    // Outstanding fetches in request order
   fetch_req_t  resp_exp;
   integer      seed = 73;
   int          exp_trans = 0;
   int          exp_hit = 0;
   int          exp_miss = 0;
   int          exp_ar = 0;
   int          exp_flush = 0;
   int          ack_count = 0;
   int          value_errors = 0;
   int          other_errors = 0;
   int          cycle_count = 0;
   int          cycle_limit;
   logic        grant_dropped = 1'b0;

   icache_top u_icache_top (
      .clk (clk), .rst_n (rst_n),
      .fetch_req_i (fetch_req_i), .fetch_grant_o (fetch_grant_o),
      .fetch_addr_i (fetch_addr_i), .fetch_id_i (fetch_id_i),
      .fetch_r_valid_o (fetch_r_valid_o), .fetch_r_rdata_o (fetch_r_rdata_o),
      .fetch_r_id_o (fetch_r_id_o),
      .m_araddr_o (m_araddr), .m_arvalid_o (m_arvalid), .m_arready_i (m_arready),
      .m_rdata_i (m_rdata), .m_rvalid_i (m_rvalid), .m_rlast_i (m_rlast),
      .m_rready_o (m_rready),
      .ctrl_flush_req_i (ctrl_flush_req_i), .ctrl_flush_ack_o (ctrl_flush_ack_o),
      .ctrl_pending_o (ctrl_pending_o),
      .stat_enable_i (stat_enable_i), .stat_clear_i (stat_clear_i),
      .hit_count_o (hit_count_o), .miss_count_o (miss_count_o),
      .trans_count_o (trans_count_o)
   );

   axi_mem_model #(.DATA_KEY (DATA_KEY)) u_mem (
      .clk (clk), .rst_n (rst_n),
      .araddr_i (m_araddr), .arvalid_i (m_arvalid), .arready_o (m_arready),
      .rdata_o (m_rdata), .rvalid_o (m_rvalid), .rlast_o (m_rlast),
      .rready_i (m_rready), .ar_count_o (ar_count)
   );

   always #20 clk = ~clk;

   // ------------------------------------------------
   // Helpers
   // ------------------------------------------------
   // Low beat of the word in the low half
   function automatic fetch_word_t expected_word(input addr_t addr);
      addr_t base;
      base = {addr[31:3], 3'b000};
      return {(base + 32'd4) ^ DATA_KEY, base ^ DATA_KEY};
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_counters();
      check_value("trans_count_o", trans_count_o, exp_trans);
      check_value("hit_count_o", hit_count_o, exp_hit);
      check_value("miss_count_o", miss_count_o, exp_miss);
      check_value("trans_count_o", trans_count_o, hit_count_o + miss_count_o);
      check_value("m_arvalid_o transfers", ar_count, exp_ar);
      check_value("ctrl_flush_ack_o pulses", ack_count, exp_flush);
      check_value("ctrl_pending_o", ctrl_pending_o, 1'b0);
   endtask

   task automatic add_row(input op_e op, input addr_t addr, input id_t id,
                          input logic hit, input logic rand_id);
      rows.push_back('{op: op, addr: addr, id: id, hit: hit, rand_id: rand_id});
   endtask

   task automatic load_table();
      add_row(OP_FETCH, 32'h0000_1000, 4'h1, 1'b0, 1'b0);    // Cold miss
      add_row(OP_SYNC, '0, '0, 1'b0, 1'b0);
      add_row(OP_FETCH, 32'h0000_1008, 4'h2, 1'b1, 1'b0);    // Other word hits
      add_row(OP_SYNC, '0, '0, 1'b0, 1'b0);
      // Set 0 eviction
      add_row(OP_FETCH, 32'h0000_2000, 4'h3, 1'b0, 1'b0);
      add_row(OP_FETCH, 32'h0000_3000, 4'h4, 1'b0, 1'b0);
      add_row(OP_FETCH, 32'h0000_1008, 4'h5, 1'b0, 1'b0);
      add_row(OP_FETCH, 32'h0000_3008, 4'h6, 1'b1, 1'b0);
      add_row(OP_SYNC, '0, '0, 1'b0, 1'b0);
      add_row(OP_FLUSH, '0, '0, 1'b0, 1'b0);
      add_row(OP_FETCH, 32'h0000_3000, 4'h7, 1'b0, 1'b0);    // Misses after flush
      add_row(OP_SYNC, '0, '0, 1'b0, 1'b0);
      add_row(OP_STAT_OFF, '0, '0, 1'b0, 1'b0);
      add_row(OP_FETCH, 32'h0000_3008, 4'h8, 1'b1, 1'b0);
      add_row(OP_FETCH, 32'h0000_4040, 4'h9, 1'b0, 1'b0);
      add_row(OP_SYNC, '0, '0, 1'b0, 1'b0);
      add_row(OP_STAT_ON, '0, '0, 1'b0, 1'b0);
      add_row(OP_CLEAR, '0, '0, 1'b0, 1'b0);
      // Back-to-back run fills the queue
      add_row(OP_FETCH, 32'h0001_0010, '0, 1'b0, 1'b1);
      add_row(OP_FETCH, 32'h0001_0020, '0, 1'b0, 1'b1);
      add_row(OP_FETCH, 32'h0001_0028, '0, 1'b1, 1'b1);
      add_row(OP_FETCH, 32'h0001_0030, '0, 1'b0, 1'b1);
      add_row(OP_FETCH, 32'h0001_0018, '0, 1'b1, 1'b1);
      add_row(OP_FETCH, 32'h0001_0040, '0, 1'b0, 1'b1);
      add_row(OP_FETCH, 32'h0000_4048, '0, 1'b1, 1'b1);      // Set 4 keeps the older line
      add_row(OP_SYNC, '0, '0, 1'b0, 1'b0);
   endtask

   task automatic issue_fetch(input row_t row);
      fetch_req_t req;
      req.addr     = row.addr;
      req.id       = row.rand_id ? id_t'($random(seed)) : row.id;
      fetch_req_i  = 1'b1;
      fetch_addr_i = req.addr;
      fetch_id_i   = req.id;
      while (!fetch_grant_o)
      begin
         grant_dropped = 1'b1;
         @(negedge clk);
      end
      exp_q.push_back(req);
      if (stat_enable_i)
      begin
         exp_trans++;
         if (row.hit)
            exp_hit++;
         else
            exp_miss++;
      end
      if (!row.hit)
         exp_ar++;
      @(negedge clk);                 // Accepted on the edge in between
      fetch_req_i = 1'b0;
      check_value("ctrl_pending_o", ctrl_pending_o, 1'b1);    // Request now held
   endtask

   task automatic wait_for_responses();
      while (exp_q.size() != 0)
         @(negedge clk);
      @(negedge clk);
   endtask

   task automatic run_row(input row_t row);
      if (row.op == OP_FETCH)
         issue_fetch(row);
      else
      begin
         wait_for_responses();
         case (row.op)
            OP_FLUSH:
            begin
               ctrl_flush_req_i = 1'b1;
               exp_flush++;
               @(negedge clk);
               ctrl_flush_req_i = 1'b0;
            end
            OP_CLEAR:
            begin
               stat_clear_i = 1'b1;
               @(negedge clk);
               stat_clear_i = 1'b0;
               exp_trans    = 0;
               exp_hit      = 0;
               exp_miss     = 0;
            end
            OP_STAT_OFF: stat_enable_i = 1'b0;
            OP_STAT_ON:  stat_enable_i = 1'b1;
            default:     ;
         endcase
         repeat (2) @(negedge clk);
         check_counters();
      end
   endtask

   // ------------------------------------------------
   // Response and flush ack monitor
   // ------------------------------------------------
   always @(negedge clk)
   begin
      if (rst_n && fetch_r_valid_o)
      begin
         assert (exp_q.size() != 0)
         else
         begin
            $display("Response arrived with no fetch outstanding");
            other_errors++;
         end
         if (exp_q.size() != 0)
         begin
            resp_exp = exp_q.pop_front();
            check_value("fetch_r_id_o", fetch_r_id_o, resp_exp.id);
            check_value("fetch_r_rdata_o", fetch_r_rdata_o, expected_word(resp_exp.addr));
         end
      end
      if (rst_n && ctrl_flush_ack_o)
         ack_count++;
   end

   // Run limit
   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= cycle_limit)
      begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         other_errors++;
         $display("Errors: %0d value, %0d other", value_errors, other_errors);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial
   begin
      clk              = 1'b0;
      rst_n            = 1'b0;
      fetch_req_i      = 1'b0;
      fetch_addr_i     = '0;
      fetch_id_i       = '0;
      ctrl_flush_req_i = 1'b0;
      stat_enable_i    = 1'b1;
      stat_clear_i     = 1'b0;
      load_table();
      cycle_limit = rows.size() * 40 + 200;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_value("fetch_grant_o", fetch_grant_o, 1'b1);    // Reset values
      check_value("fetch_r_valid_o", fetch_r_valid_o, 1'b0);
      check_value("m_arvalid_o", m_arvalid, 1'b0);
      check_value("m_rready_o", m_rready, 1'b0);
      check_value("ctrl_flush_ack_o", ctrl_flush_ack_o, 1'b0);
      check_value("ctrl_pending_o", ctrl_pending_o, 1'b0);
      for (int i = 0; i < rows.size(); i++)
         run_row(rows[i]);
      wait_for_responses();
      check_counters();
      assert (grant_dropped)
      else
      begin
         $display("Fetch grant never dropped while the queue was full");
         other_errors++;
      end
      $display("Errors: %0d value, %0d other", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/icache_pkg.sv
common/icache_if.sv
hdl/fetch_req_queue.sv
icache_core/icache_ctrl.sv
icache_core/icache_ways.sv
axi_refill/axi_refill.sv
hdl/icache_top.sv
sim/axi_mem_model.sv
sim/icache_tb.sv
